// File: hw/idu_defines.svh
// Decode front parameters
`ifndef IDU_DEFINES_SVH
`define IDU_DEFINES_SVH

// Datapath widths
`define IDU_IW 32
`define IDU_DW 32
`define IDU_REG_AW 5

// Register written by jump-and-link
`define IDU_REGNO_LNK 1

// Fetch queue entries
// Pointers wrap by overflow so this must stay a power of two
`define IDU_FQ_DEPTH 4

// APB register offsets
`define IDU_ADDR_INSN 32'h0000_0000
`define IDU_ADDR_EXC 32'h0000_0004
`define IDU_ADDR_STATUS 32'h0000_0008

// Long-latency unit opcodes
// Set a switch to 0 and its opcode decodes as an emulated instruction
`define IDU_ENABLE_MUL 1
`define IDU_ENABLE_DIV 1
`define IDU_ENABLE_DIVU 1
`define IDU_ENABLE_MOD 1
`define IDU_ENABLE_MODU 1

`endif

// File: hw/idu_pkg.sv
// Decode front types
`default_nettype none
`include "idu_defines.svh"

package idu_pkg;

   // Major opcode in bits 6:0
   // OP_AND with all fields zero is the NOP
   typedef enum logic [6:0] {
      OP_AND = 7'h00, OP_AND_I = 7'h01, OP_OR = 7'h02, OP_OR_I = 7'h03,
      OP_XOR = 7'h04, OP_XOR_I = 7'h05, OP_LSL = 7'h06, OP_LSL_I = 7'h07,
      OP_LSR = 7'h08, OP_LSR_I = 7'h09, OP_ASR = 7'h0a, OP_ASR_I = 7'h0b,
      OP_ADD = 7'h0c, OP_ADD_I = 7'h0d, OP_SUB = 7'h0e,
      OP_MUL = 7'h0f, OP_DIV = 7'h10, OP_DIVU = 7'h11, OP_MOD = 7'h12, OP_MODU = 7'h13,
      OP_MHI = 7'h14,
      // Memory access
      OP_LDB = 7'h15, OP_LDBU = 7'h16, OP_LDH = 7'h17, OP_LDHU = 7'h18, OP_LDWU = 7'h19,
      OP_STB = 7'h1a, OP_STH = 7'h1b, OP_STW = 7'h1c, OP_MBARR = 7'h1d,
      // Control flow
      OP_JMP_I = 7'h1e, OP_JMP_LNK_I = 7'h1f, OP_JMP = 7'h20,
      OP_BEQ = 7'h21, OP_BNE = 7'h22, OP_BGT = 7'h23, OP_BGTU = 7'h24,
      OP_BLE = 7'h25, OP_BLEU = 7'h26,
      // System
      OP_SYSCALL = 7'h27, OP_RET = 7'h28, OP_WMSR = 7'h29, OP_RMSR = 7'h2a
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_NONE, ALU_AND, ALU_OR, ALU_XOR, ALU_LSL, ALU_LSR, ALU_ASR,
      ALU_ADD, ALU_SUB, ALU_MHI
   } alu_op_e;

   typedef enum logic [2:0] {
      LPU_NONE, LPU_MUL, LPU_DIV, LPU_DIVU, LPU_MOD, LPU_MODU
   } lpu_op_e;

   // Conditional branches stay contiguous from BEQ to BLEU
   typedef enum logic [3:0] {
      BRU_NONE, BRU_BEQ, BRU_BNE, BRU_BGT, BRU_BGTU, BRU_BLE, BRU_BLEU,
      BRU_JMPREL, BRU_JMPREG
   } bru_op_e;

   typedef enum logic [3:0] {
      EPU_NONE, EPU_WMSR, EPU_RMSR, EPU_ESYSCALL, EPU_ERET,
      EPU_EITM, EPU_EIPF, EPU_EIRQ, EPU_EINSN
   } epu_op_e;

   typedef enum logic [1:0] {
      SIZE_NONE, SIZE_BYTE, SIZE_HALF, SIZE_WORD
   } mem_size_e;

   typedef enum logic [`IDU_DW-1:0] {
      REG_INSN   = `IDU_ADDR_INSN,
      REG_EXC    = `IDU_ADDR_EXC,
      REG_STATUS = `IDU_ADDR_STATUS
   } apb_reg_e;

   typedef struct packed {
      logic [`IDU_IW-1:0] insn;
      logic               itm;
      logic               ipf;
      logic               irq;
   } fetch_entry_t;

   typedef struct packed {
      alu_op_e                alu_op;
      lpu_op_e                lpu_op;
      bru_op_e                bru_op;
      epu_op_e                epu_op;
      logic                   lsu_load;
      logic                   lsu_store;
      logic                   lsu_barr;
      logic                   lsu_sign_ext;
      mem_size_e              load_size;
      mem_size_e              store_size;
      logic                   wb_en;
      logic [`IDU_REG_AW-1:0] wb_addr;
      logic [`IDU_DW-1:0]     imm32;
      logic                   rs1_re;
      logic [`IDU_REG_AW-1:0] rs1_addr;
      logic                   rs2_re;
      logic [`IDU_REG_AW-1:0] rs2_addr;
   } dec_bundle_t;

endpackage

`default_nettype wire

// File: hw/apb_insn_port.sv
// APB instruction port
`timescale 1ns/1ns
`default_nettype none
`include "idu_defines.svh"

module apb_insn_port
(
   input  wire                   clk,
   input  wire                   rst_n_i,
   input  wire                   psel_i,
   input  wire                   penable_i,
   input  wire                   pwrite_i,
   input  wire [`IDU_DW-1:0]     paddr_i,
   input  wire [`IDU_DW-1:0]     pwdata_i,
   input  wire                   pop_i,
   output logic [`IDU_DW-1:0]    prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   output idu_pkg::fetch_entry_t head_o,
   output logic                  head_valid_o
);

   localparam int PW = $clog2(`IDU_FQ_DEPTH);
   localparam int CW = $clog2(`IDU_FQ_DEPTH + 1);

   idu_pkg::fetch_entry_t fq_mem [`IDU_FQ_DEPTH];
   logic [PW-1:0]         wr_ptr;
   logic [PW-1:0]         rd_ptr;
   logic [CW-1:0]         count;
   // Pending flags with irq in bit 2, ipf in bit 1 and itm in bit 0
   logic [2:0]            exc_q;
   logic                  access;
   logic                  sel_insn;
   logic                  sel_exc;
   logic                  sel_status;
   logic                  full;
   logic                  push;
   logic                  exc_wr;

   assign access = psel_i & penable_i;
   assign sel_insn = (paddr_i == idu_pkg::REG_INSN);
   assign sel_exc = (paddr_i == idu_pkg::REG_EXC);
   assign sel_status = (paddr_i == idu_pkg::REG_STATUS);
   assign full = (count == CW'(`IDU_FQ_DEPTH));

   // Wait states on INSN writes until an entry leaves
   assign pready_o = access & ~(pwrite_i & sel_insn & full);

   // Only INSN and EXC writes and STATUS reads are legal
   assign pslverr_o = access & ~((pwrite_i & (sel_insn | sel_exc)) | (~pwrite_i & sel_status));
   assign prdata_o = (access & ~pwrite_i & sel_status) ? `IDU_DW'(count) : '0;

   assign push = pready_o & pwrite_i & sel_insn;
   assign exc_wr = pready_o & pwrite_i & sel_exc;

   assign head_o = fq_mem[rd_ptr];
   assign head_valid_o = (count != '0);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
         exc_q <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_i)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count + CW'(push) - CW'(pop_i);
         // Flags travel with the next word only
         if (push)
            exc_q <= '0;
         else if (exc_wr)
            exc_q <= pwdata_i[2:0];
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         fq_mem[wr_ptr] <= '{insn: pwdata_i[`IDU_IW-1:0], itm: exc_q[0], ipf: exc_q[1],
                             irq: exc_q[2]};
   end

   // A push never lands on an entry that is still waiting
   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
                                    push |-> (count == '0) || (wr_ptr != rd_ptr))
      else $error("apb_insn_port: push into a full fetch queue");

   // Issue stage must only take a valid head
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i) pop_i |-> head_valid_o)
      else $error("apb_insn_port: pop from an empty fetch queue");

endmodule

`default_nettype wire

// File: hw/insn_decoder.sv
// Instruction decoder
`timescale 1ns/1ns
`default_nettype none
`include "idu_defines.svh"

module insn_decoder
(
   input  wire idu_pkg::fetch_entry_t entry_i,
   output idu_pkg::dec_bundle_t       bundle_o
);

   idu_pkg::opcode_e       opcode;
   logic                   fnt_exc;
   logic [`IDU_REG_AW-1:0] f_rd;
   logic [`IDU_REG_AW-1:0] f_rs1;
   logic [`IDU_REG_AW-1:0] f_rs2;
   logic [14:0]            f_imm15;
   logic [16:0]            f_imm17;
   logic [24:0]            f_rel25;
   logic                   alu_imm;
   logic                   bcc;
   logic                   form_imm15;
   logic                   form_rd_imm15;
   logic                   form_imm17;
   logic                   form_rel25;
   logic                   imm15_signed;
   logic                   no_rops;
   logic                   no_wb;

   assign fnt_exc = entry_i.itm | entry_i.ipf | entry_i.irq;

   // A frontend exception displaces the word with a NOP
   assign opcode = idu_pkg::opcode_e'(entry_i.insn[6:0] & {7{~fnt_exc}});
   assign f_rd = entry_i.insn[11:7];
   assign f_rs1 = entry_i.insn[16:12];
   assign f_rs2 = entry_i.insn[21:17];
   assign f_imm15 = entry_i.insn[31:17];
   assign f_imm17 = entry_i.insn[28:12];
   assign f_rel25 = entry_i.insn[31:7];

   assign alu_imm = opcode inside {idu_pkg::OP_AND_I, idu_pkg::OP_OR_I, idu_pkg::OP_XOR_I,
                                   idu_pkg::OP_LSL_I, idu_pkg::OP_LSR_I, idu_pkg::OP_ASR_I,
                                   idu_pkg::OP_ADD_I};

   always_comb
   begin
      bundle_o = '0;
      case (opcode)
         idu_pkg::OP_AND: if (!fnt_exc) bundle_o.alu_op = idu_pkg::ALU_AND;
         idu_pkg::OP_AND_I: bundle_o.alu_op = idu_pkg::ALU_AND;
         idu_pkg::OP_OR, idu_pkg::OP_OR_I: bundle_o.alu_op = idu_pkg::ALU_OR;
         idu_pkg::OP_XOR, idu_pkg::OP_XOR_I: bundle_o.alu_op = idu_pkg::ALU_XOR;
         idu_pkg::OP_LSL, idu_pkg::OP_LSL_I: bundle_o.alu_op = idu_pkg::ALU_LSL;
         idu_pkg::OP_LSR, idu_pkg::OP_LSR_I: bundle_o.alu_op = idu_pkg::ALU_LSR;
         idu_pkg::OP_ASR, idu_pkg::OP_ASR_I: bundle_o.alu_op = idu_pkg::ALU_ASR;
         idu_pkg::OP_ADD, idu_pkg::OP_ADD_I: bundle_o.alu_op = idu_pkg::ALU_ADD;
         idu_pkg::OP_SUB: bundle_o.alu_op = idu_pkg::ALU_SUB;
         idu_pkg::OP_MHI: bundle_o.alu_op = idu_pkg::ALU_MHI;
         // Disabled units leave the opcode unclaimed
         idu_pkg::OP_MUL: if (`IDU_ENABLE_MUL) bundle_o.lpu_op = idu_pkg::LPU_MUL;
         idu_pkg::OP_DIV: if (`IDU_ENABLE_DIV) bundle_o.lpu_op = idu_pkg::LPU_DIV;
         idu_pkg::OP_DIVU: if (`IDU_ENABLE_DIVU) bundle_o.lpu_op = idu_pkg::LPU_DIVU;
         idu_pkg::OP_MOD: if (`IDU_ENABLE_MOD) bundle_o.lpu_op = idu_pkg::LPU_MOD;
         idu_pkg::OP_MODU: if (`IDU_ENABLE_MODU) bundle_o.lpu_op = idu_pkg::LPU_MODU;
         idu_pkg::OP_LDB, idu_pkg::OP_LDBU: bundle_o.load_size = idu_pkg::SIZE_BYTE;
         idu_pkg::OP_LDH, idu_pkg::OP_LDHU: bundle_o.load_size = idu_pkg::SIZE_HALF;
         idu_pkg::OP_LDWU: bundle_o.load_size = idu_pkg::SIZE_WORD;
         idu_pkg::OP_STB: bundle_o.store_size = idu_pkg::SIZE_BYTE;
         idu_pkg::OP_STH: bundle_o.store_size = idu_pkg::SIZE_HALF;
         idu_pkg::OP_STW: bundle_o.store_size = idu_pkg::SIZE_WORD;
         idu_pkg::OP_MBARR: bundle_o.lsu_barr = 1'b1;
         idu_pkg::OP_JMP_I, idu_pkg::OP_JMP_LNK_I: bundle_o.bru_op = idu_pkg::BRU_JMPREL;
         idu_pkg::OP_JMP: bundle_o.bru_op = idu_pkg::BRU_JMPREG;
         idu_pkg::OP_BEQ: bundle_o.bru_op = idu_pkg::BRU_BEQ;
         idu_pkg::OP_BNE: bundle_o.bru_op = idu_pkg::BRU_BNE;
         idu_pkg::OP_BGT: bundle_o.bru_op = idu_pkg::BRU_BGT;
         idu_pkg::OP_BGTU: bundle_o.bru_op = idu_pkg::BRU_BGTU;
         idu_pkg::OP_BLE: bundle_o.bru_op = idu_pkg::BRU_BLE;
         idu_pkg::OP_BLEU: bundle_o.bru_op = idu_pkg::BRU_BLEU;
         idu_pkg::OP_SYSCALL: bundle_o.epu_op = idu_pkg::EPU_ESYSCALL;
         idu_pkg::OP_RET: bundle_o.epu_op = idu_pkg::EPU_ERET;
         idu_pkg::OP_WMSR: bundle_o.epu_op = idu_pkg::EPU_WMSR;
         idu_pkg::OP_RMSR: bundle_o.epu_op = idu_pkg::EPU_RMSR;
         default: bundle_o.lsu_barr = 1'b0;
      endcase

      bundle_o.lsu_load = (bundle_o.load_size != idu_pkg::SIZE_NONE);
      bundle_o.lsu_store = (bundle_o.store_size != idu_pkg::SIZE_NONE);
      bundle_o.lsu_sign_ext = (opcode == idu_pkg::OP_LDB) || (opcode == idu_pkg::OP_LDH);

      // Unclaimed opcodes are emulated
      if (bundle_o.alu_op == idu_pkg::ALU_NONE && bundle_o.lpu_op == idu_pkg::LPU_NONE &&
          bundle_o.bru_op == idu_pkg::BRU_NONE && bundle_o.epu_op == idu_pkg::EPU_NONE &&
          !bundle_o.lsu_load && !bundle_o.lsu_store && !bundle_o.lsu_barr)
         bundle_o.epu_op = idu_pkg::EPU_EINSN;

      // Frontend exceptions, irq first
      if (entry_i.irq)
         bundle_o.epu_op = idu_pkg::EPU_EIRQ;
      else if (entry_i.itm)
         bundle_o.epu_op = idu_pkg::EPU_EITM;
      else if (entry_i.ipf)
         bundle_o.epu_op = idu_pkg::EPU_EIPF;

      bcc = bundle_o.bru_op inside {[idu_pkg::BRU_BEQ:idu_pkg::BRU_BLEU]};
      form_imm15 = alu_imm || bundle_o.lsu_load || (bundle_o.epu_op == idu_pkg::EPU_RMSR);
      // Forms that also read rd through the rs2 port
      form_rd_imm15 = bundle_o.lsu_store || (bundle_o.epu_op == idu_pkg::EPU_WMSR) || bcc;
      form_imm17 = (bundle_o.alu_op == idu_pkg::ALU_MHI);
      form_rel25 = (bundle_o.bru_op == idu_pkg::BRU_JMPREL);
      imm15_signed = (opcode == idu_pkg::OP_XOR_I) || (opcode == idu_pkg::OP_ADD_I) ||
                     bundle_o.lsu_load || bundle_o.lsu_store;
      no_rops = form_imm17 || form_rel25 || bundle_o.lsu_barr ||
                (bundle_o.epu_op inside {idu_pkg::EPU_ESYSCALL, idu_pkg::EPU_ERET});

      // Every EPU operation but RMSR leaves the register file alone
      no_wb = bcc || bundle_o.lsu_store || bundle_o.lsu_barr || (opcode == idu_pkg::OP_JMP_I) ||
              (bundle_o.epu_op != idu_pkg::EPU_NONE && bundle_o.epu_op != idu_pkg::EPU_RMSR);

      if (opcode == idu_pkg::OP_JMP_LNK_I)
         bundle_o.wb_addr = `IDU_REG_AW'(`IDU_REGNO_LNK);
      else
         bundle_o.wb_addr = f_rd;
      // r0 is never written
      bundle_o.wb_en = !no_wb && (bundle_o.wb_addr != '0);

      bundle_o.rs1_re = !no_rops;
      bundle_o.rs1_addr = f_rs1;
      bundle_o.rs2_re = (!form_imm15 && !form_imm17 && !form_rel25 && !no_rops) ||
                        form_rd_imm15;
      bundle_o.rs2_addr = form_rd_imm15 ? f_rd : f_rs2;

      if (form_imm15 || form_rd_imm15)
      begin
         if (imm15_signed)
            bundle_o.imm32 = {{(`IDU_DW - 15){f_imm15[14]}}, f_imm15};
         else
            bundle_o.imm32 = {{(`IDU_DW - 15){1'b0}}, f_imm15};
      end
      else if (form_imm17)
         bundle_o.imm32 = {{(`IDU_DW - 17){1'b0}}, f_imm17};
      else if (form_rel25)
         bundle_o.imm32 = {{(`IDU_DW - 27){f_rel25[24]}}, f_rel25, 2'b00};

      // Immediate forms are exclusive across the whole opcode map
      a_one_imm_form: assert ($isunknown(entry_i.insn) ||
                              $onehot0({form_imm15, form_rd_imm15, form_imm17, form_rel25}))
         else $error("insn_decoder: several immediate forms for opcode %0h", opcode);
   end

endmodule

`default_nettype wire

// File: hw/issue_stage.sv
// Issue register
`timescale 1ns/1ns
`default_nettype none

module issue_stage
(
   input  wire                       clk,
   input  wire                       rst_n_i,
   input  wire idu_pkg::dec_bundle_t bundle_i,
   input  wire                       bundle_valid_i,
   input  wire                       issue_ready_i,
   output logic                      take_o,
   output idu_pkg::dec_bundle_t      issue_o,
   output logic                      issue_valid_o
);

   // Load when empty or when the held bundle leaves on this edge
   assign take_o = bundle_valid_i & (~issue_valid_o | issue_ready_i);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         issue_valid_o <= 1'b0;
      else if (take_o)
         issue_valid_o <= 1'b1;
      else if (issue_ready_i)
         issue_valid_o <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (take_o)
         issue_o <= bundle_i;
   end

   // Held bundle stays put until downstream accepts it
   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
                                   issue_valid_o && !issue_ready_i
                                   |=> issue_valid_o && $stable(issue_o))
      else $error("issue_stage: bundle changed under back-pressure");

endmodule

`default_nettype wire

// File: hw/idu_top.sv
// Instruction decode front
`timescale 1ns/1ns
`default_nettype none
`include "idu_defines.svh"

module idu_top
(
   input  wire                  clk,
   input  wire                  rst_n_i,
   input  wire                  psel_i,
   input  wire                  penable_i,
   input  wire                  pwrite_i,
   input  wire [`IDU_DW-1:0]    paddr_i,
   input  wire [`IDU_DW-1:0]    pwdata_i,
   output logic [`IDU_DW-1:0]   prdata_o,
   output logic                 pready_o,
   output logic                 pslverr_o,
   output idu_pkg::dec_bundle_t issue_o,
   output logic                 issue_valid_o,
   input  wire                  issue_ready_i
);

   idu_pkg::fetch_entry_t head;
   logic                  head_valid;
   idu_pkg::dec_bundle_t  bundle;
   logic                  take;

   apb_insn_port u_port
   (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .pop_i        (take),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .head_o       (head),
      .head_valid_o (head_valid)
   );

   insn_decoder u_decoder
   (
      .entry_i  (head),
      .bundle_o (bundle)
   );

   issue_stage u_issue
   (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .bundle_i       (bundle),
      .bundle_valid_i (head_valid),
      .issue_ready_i  (issue_ready_i),
      .take_o         (take),
      .issue_o        (issue_o),
      .issue_valid_o  (issue_valid_o)
   );

endmodule

`default_nettype wire

// File: tb/idu_tb.sv
// Decode front testbench
`timescale 1ns/1ns
`default_nettype none
`include "idu_defines.svh"

module idu_tb;

   logic                 clk;
   logic                 rst_n_i;
   logic                 psel_i;
   logic                 penable_i;
   logic                 pwrite_i;
   logic [`IDU_DW-1:0]   paddr_i;
   logic [`IDU_DW-1:0]   pwdata_i;
   logic [`IDU_DW-1:0]   prdata_o;
   logic                 pready_o;
   logic                 pslverr_o;
   idu_pkg::dec_bundle_t issue_o;
   logic                 issue_valid_o;
   logic                 issue_ready_i;

   // Bundles in push order, popped on every transfer
   idu_pkg::dec_bundle_t exp_q[$];
   string                vectors[$];
   int                   cycle = 0;
   int                   hold_until = 0;
   bit                   loaded = 1'b0;

   idu_top dut (.*);

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Done: errors found");
      $fatal(1, "run stopped");
   endtask

   task automatic check_bundle(input idu_pkg::dec_bundle_t got, input idu_pkg::dec_bundle_t exp);
      if (got !== exp)
         abort_run($sformatf("** Error at %0t ns: issue_o is %h, expected %h", $time, got, exp));
   endtask

   task automatic check_rdata(input logic [`IDU_DW-1:0] got, input logic [`IDU_DW-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("** Error at %0t ns: prdata_o is %h, expected %h", $time, got, exp));
   endtask

   task automatic check_slverr(input logic got, input logic exp);
      if (got !== exp)
         abort_run($sformatf("** Error at %0t ns: pslverr_o is %b, expected %b", $time, got, exp));
   endtask

   // One APB transfer through setup and access phases until pready_o
   task automatic apb_access(input logic wr, input logic [`IDU_DW-1:0] addr,
                             input logic [`IDU_DW-1:0] data,
                             output logic [`IDU_DW-1:0] rdata, output logic slverr);
      @(posedge clk);
      psel_i <= 1'b1;
      pwrite_i <= wr;
      paddr_i <= addr;
      pwdata_i <= data;
      @(posedge clk);
      penable_i <= 1'b1;
      @(negedge clk);
      while (!pready_o)
         @(negedge clk);
      rdata = prdata_o;
      slverr = pslverr_o;
      @(posedge clk);
      psel_i <= 1'b0;
      penable_i <= 1'b0;
   endtask

   // Downstream side with random ready
   initial
   begin
      issue_ready_i = 1'b0;
      void'($urandom(49));
      forever
      begin
         @(negedge clk);
         if (rst_n_i && issue_valid_o && issue_ready_i)
         begin
            if (exp_q.size() == 0)
               abort_run("A bundle was issued with no instruction left to expect");
            else
               check_bundle(issue_o, exp_q.pop_front());
         end
         @(posedge clk);
         cycle <= cycle + 1;
         if (cycle < hold_until)
            issue_ready_i <= 1'b0;
         else
            issue_ready_i <= 1'($urandom % 2);
      end
   end

   initial
   begin
      wait (loaded);
      #(vectors.size() * 50 * 8 + 1000);
      abort_run("Watchdog expired before the test vectors completed");
   end

   initial
   begin
      int                 fd;
      int                 waited;
      string              line;
      logic [31:0]        kind;
      logic [31:0]        v[18];
      logic [`IDU_DW-1:0] rdata;
      logic               slverr;
      psel_i = 1'b0;
      penable_i = 1'b0;
      pwrite_i = 1'b0;
      paddr_i = '0;
      pwdata_i = '0;
      rst_n_i = 1'b0;
      fd = $fopen("tb/idu_testdata.txt", "r");
      if (fd == 0)
         abort_run("Cannot open tb/idu_testdata.txt");
      while (!$feof(fd))
      begin
         if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#")
            vectors.push_back(line);
      end
      $fclose(fd);
      loaded = 1'b1;
      repeat (5) @(posedge clk);
      rst_n_i <= 1'b1;
      foreach (vectors[i])
      begin
         void'($sscanf(vectors[i], "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       kind, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                       v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17]));
         case (kind)
            "EXC":
            begin
               apb_access(1'b1, `IDU_ADDR_EXC, v[0], rdata, slverr);
               check_slverr(slverr, 1'b0);
            end
            "INSN":
            begin
               // Fields in dec_bundle_t order, MSB first
               exp_q.push_back({v[1][3:0], v[2][2:0], v[3][3:0], v[4][3:0], v[5][0], v[6][0],
                                v[7][0], v[8][0], v[9][1:0], v[10][1:0], v[11][0], v[12][4:0],
                                v[13], v[14][0], v[15][4:0], v[16][0], v[17][4:0]});
               apb_access(1'b1, `IDU_ADDR_INSN, v[0], rdata, slverr);
               check_slverr(slverr, 1'b0);
            end
            "RD":
            begin
               apb_access(1'b0, v[0], '0, rdata, slverr);
               check_slverr(slverr, 1'b0);
               check_rdata(rdata, v[1]);
            end
            "ERR":
            begin
               // Zero data would clear the pending flags if it leaked into EXC
               apb_access(v[0][0], v[1], '0, rdata, slverr);
               check_slverr(slverr, 1'b1);
            end
            "HOLD":
            begin
               // Drain first and then hold ready low
               while (exp_q.size() != 0)
                  @(negedge clk);
               hold_until = cycle + int'(v[0]);
            end
            default:
               abort_run($sformatf("Unknown vector kind in line: %s", vectors[i]));
         endcase
      end
      waited = 0;
      while (exp_q.size() != 0 && waited < 200)
      begin
         @(negedge clk);
         waited++;
      end
      if (exp_q.size() != 0)
         abort_run($sformatf("%0d bundles never left the issue port", exp_q.size()));
      else
      begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: tb/idu_testdata.txt
# Hex columns: EXC flags | RD addr data | ERR write addr | HOLD cycles | INSN word, then
# alu lpu bru epu ld st barr sext ld_size st_size wb_en wb_addr imm32 rs1_re rs1 rs2_re rs2
RD 8 0
INSN 0004118c 7 0 0 0 0 0 0 0 0 0 1 03 00000000 1 01 1 02
INSN fffa428d 7 0 0 0 0 0 0 0 0 0 1 05 fffffffd 1 04 0 1d
INSN 80002105 3 0 0 0 0 0 0 0 0 0 1 02 ffffc000 1 02 0 00
INSN 1abcd594 9 0 0 0 0 0 0 0 0 0 1 0b 0001abcd 0 0d 0 1e
INSN 001cd60f 0 1 0 0 0 0 0 0 0 0 1 0c 00000000 1 0d 1 0e
INSN fff05215 0 0 0 0 1 0 0 1 1 0 1 04 fffffff8 1 05 0 18
INSN 00207318 0 0 0 0 1 0 0 0 2 0 1 06 00000010 1 07 0 10
INSN 00081019 0 0 0 0 1 0 0 0 3 0 0 00 00000004 1 01 0 04
INSN fffe249a 0 0 0 0 0 1 0 0 0 1 0 09 ffffffff 1 02 1 09
INSN 0000001d 0 0 0 0 0 0 1 0 0 0 0 00 00000000 0 00 0 00
INSN fffff81e 0 0 7 0 0 0 0 0 0 0 0 10 ffffffc0 0 1f 0 1f
INSN 0000919f 0 0 7 0 0 0 0 0 0 0 1 01 0000048c 0 09 0 00
INSN ffe07324 0 0 4 0 0 0 0 0 0 0 0 06 00007ff0 1 07 1 06
INSN 00000027 0 0 0 3 0 0 0 0 0 0 0 00 00000000 0 00 0 00
INSN 002441a9 0 0 0 1 0 0 0 0 0 0 0 03 00000012 1 04 1 03
INSN 800a83aa 0 0 0 2 0 0 0 0 0 0 1 07 00004005 1 08 0 05
INSN 000412ff 0 0 0 8 0 0 0 0 0 0 0 05 00000000 1 01 1 02
INSN 0002100c 7 0 0 0 0 0 0 0 0 0 0 00 00000000 1 01 1 01
EXC 7
INSN 0004118c 0 0 0 7 0 0 0 0 0 0 0 03 00000000 1 01 1 02
INSN 0004118c 7 0 0 0 0 0 0 0 0 0 1 03 00000000 1 01 1 02
EXC 3
INSN 1abcd594 0 0 0 5 0 0 0 0 0 0 0 0b 00000000 1 0d 1 1e
EXC 2
INSN fff05215 0 0 0 6 0 0 0 0 0 0 0 04 00000000 1 05 1 18
EXC 6
ERR 1 8
ERR 1 c
ERR 0 0
ERR 0 4
INSN 00230791 0 0 0 7 0 0 0 0 0 0 0 0f 00000000 1 10 1 11
HOLD 0
RD 8 0
HOLD 3c
INSN 00230791 0 3 0 0 0 0 0 0 0 0 1 0f 00000000 1 10 1 11
INSN 0014940a 6 0 0 0 0 0 0 0 0 0 1 08 00000000 1 09 1 0a
INSN 00005120 0 0 8 0 0 0 0 0 0 0 1 02 00000000 1 05 1 00
INSN 00000028 0 0 0 4 0 0 0 0 0 0 0 00 00000000 0 00 0 00
INSN 80027303 2 0 0 0 0 0 0 0 0 0 1 06 00004001 1 07 0 01
RD 8 4
INSN 001020a5 0 0 5 0 0 0 0 0 0 0 0 01 00000008 1 02 1 01
HOLD 0
RD 8 0

// File: sources.f
+incdir+hw
hw/idu_pkg.sv
hw/apb_insn_port.sv
hw/insn_decoder.sv
hw/issue_stage.sv
hw/idu_top.sv
tb/idu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the decode front testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module idu_tb -o idu_tb_sim
./obj_dir/idu_tb_sim
